// File: filelist.f
verilog/cbc_pkg.sv
verilog/core_bus_if.sv
verilog/block_assembler.sv
verilog/cbc_controller.sv
verilog/iv_chain.sv
verilog/axis_output_skid.sv
verilog/aes_cbc_decrypt_top.sv
verification/aes_core_model.sv
verification/tb_aes_cbc_decrypt.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aes_cbc_decrypt
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_aes_cbc_decrypt.sv
`timescale 1ns/1ps

module tb_aes_cbc_decrypt import cbc_pkg::*; ();

  typedef struct packed {
    int   blocks;
    logic stall;
    logic new_key;
  } test_t;

  localparam int NUM_TESTS = 8;

  // blocks per message, sink stalls, reset and new key before the message
  localparam test_t TESTS [NUM_TESTS] = '{
    '{blocks: 1, stall: 1'b0, new_key: 1'b1},
    '{blocks: 3, stall: 1'b0, new_key: 1'b0},
    '{blocks: 4, stall: 1'b0, new_key: 1'b0},
    '{blocks: 5, stall: 1'b1, new_key: 1'b0},
    '{blocks: 9, stall: 1'b0, new_key: 1'b0},
    '{blocks: 2, stall: 1'b1, new_key: 1'b0},
    '{blocks: 3, stall: 1'b0, new_key: 1'b1},
    '{blocks: 9, stall: 1'b1, new_key: 1'b0}
  };

  logic              clk;
  logic              reset_n;
  logic [BEAT_W-1:0] key_tdata;
  logic              key_tvalid;
  logic              key_tready;
  logic [BEAT_W-1:0] ct_tdata;
  logic              ct_tvalid;
  logic              ct_tready;
  logic              ct_tlast;
  logic [BEAT_W-1:0] pt_tdata;
  logic              pt_tvalid;
  logic              pt_tready;
  logic              pt_tlast;

  logic [31:0]        lfsr_state = 32'he37f;
  logic [BLOCK_W-1:0] key;
  logic [BLOCK_W-1:0] ct_blocks [$];
  logic [BEAT_W-1:0]  expected_beats [$];
  int                 errors = 0;
  int                 checks = 0;

  aes_cbc_decrypt_top dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .key_tdata  (key_tdata),
    .key_tvalid (key_tvalid),
    .key_tready (key_tready),
    .ct_tdata   (ct_tdata),
    .ct_tvalid  (ct_tvalid),
    .ct_tready  (ct_tready),
    .ct_tlast   (ct_tlast),
    .pt_tdata   (pt_tdata),
    .pt_tvalid  (pt_tvalid),
    .pt_tready  (pt_tready),
    .pt_tlast   (pt_tlast)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ------------------------------------------------------------------------
  // data helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [BEAT_W-1:0] random_bits(input int n);
    logic [BEAT_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[BEAT_W-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [BLOCK_W-1:0] random_block();
    logic [BLOCK_W-1:0] b;
    b[BLOCK_W-1:BEAT_W] = random_bits(BEAT_W);
    b[BEAT_W-1:0]       = random_bits(BEAT_W);
    return b;
  endfunction

  // block byte i goes to tdata byte i mod 8 of beat i/8
  function automatic logic [BEAT_W-1:0] beat_of(input logic [BLOCK_W-1:0] b, input int w);
    logic [BEAT_W-1:0] beat;
    int                i;
    for (int j = 0; j < 8; j++) begin
      i = 8 * w + j;
      beat[8 * j +: 8] = b[8 * (15 - i) +: 8];
    end
    return beat;
  endfunction

  function automatic int watchdog_cycles();
    int n;
    n = 500;
    for (int t = 0; t < NUM_TESTS; t++) begin
      n += 200 * TESTS[t].blocks;
    end
    return n;
  endfunction

  // ------------------------------------------------------------------------
  // stream tasks entered 1 ns after a rising edge
  // ------------------------------------------------------------------------
  task automatic apply_reset();
    reset_n    = 1'b0;
    key_tvalid = 1'b0;
    ct_tvalid  = 1'b0;
    ct_tlast   = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;
  endtask

  task automatic check_idle();
    for (int i = 0; i < 4; i++) begin
      checks++;
      if (key_tready !== 1'b0) begin
        $display("ERROR at %0t: key_tready expected 0, got %b", $time, key_tready);
        errors++;
      end
      if (ct_tready !== 1'b0) begin
        $display("ERROR at %0t: ct_tready expected 0, got %b", $time, ct_tready);
        errors++;
      end
      if (pt_tvalid !== 1'b0) begin
        $display("ERROR at %0t: pt_tvalid expected 0, got %b", $time, pt_tvalid);
        errors++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_no_stray_beats(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      checks++;
      if (pt_tvalid !== 1'b0) begin
        $display("ERROR at %0t: pt_tvalid expected 0, got %b", $time, pt_tvalid);
        errors++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_key_beat(input logic [BEAT_W-1:0] data);
    key_tdata  = data;
    key_tvalid = 1'b1;
    while (!key_tready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_ct_beat(input logic [BEAT_W-1:0] data, input logic last);
    ct_tdata  = data;
    ct_tlast  = last;
    ct_tvalid = 1'b1;
    while (!ct_tready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_message(input logic [BLOCK_W-1:0] iv, input int n);
    send_ct_beat(beat_of(iv, 0), 1'b0);
    send_ct_beat(beat_of(iv, 1), 1'b0);
    for (int k = 0; k < n; k++) begin
      send_ct_beat(beat_of(ct_blocks[k], 0), 1'b0);
      send_ct_beat(beat_of(ct_blocks[k], 1), k == n - 1);
    end
    ct_tvalid = 1'b0;
    ct_tlast  = 1'b0;
  endtask

  task automatic collect_plaintext(input logic stall, input int n);
    logic [BEAT_W-1:0] r;
    logic [BEAT_W-1:0] exp;
    logic              exp_last;
    int                got;
    got = 0;
    while (got < n) begin
      if (stall) begin
        r = random_bits(1);
        pt_tready = r[0];
      end else begin
        pt_tready = 1'b1;
      end
      if (pt_tvalid && pt_tready) begin
        exp      = expected_beats[got];
        exp_last = got == n - 1;
        checks++;
        if (pt_tdata !== exp) begin
          $display("ERROR at %0t: pt_tdata expected %h, got %h", $time, exp, pt_tdata);
          errors++;
        end
        if (pt_tlast !== exp_last) begin
          $display("ERROR at %0t: pt_tlast expected %b, got %b", $time, exp_last, pt_tlast);
          errors++;
        end
        got++;
      end
      @(posedge clk);
      #1;
    end
    pt_tready = 1'b1;
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin : main
    logic [BLOCK_W-1:0] iv;
    logic [BLOCK_W-1:0] prev;
    logic [BLOCK_W-1:0] plain;
    int                 start_errors;
    reset_n    = 1'b0;
    key_tdata  = '0;
    key_tvalid = 1'b0;
    ct_tdata   = '0;
    ct_tvalid  = 1'b0;
    ct_tlast   = 1'b0;
    pt_tready  = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      start_errors = errors;
      if (TESTS[t].new_key) begin
        apply_reset();
        check_idle();
        key = random_block();
        send_key_beat(beat_of(key, 0));
        send_key_beat(beat_of(key, 1));
        key_tvalid = 1'b0;
      end
      iv = random_block();
      ct_blocks.delete();
      expected_beats.delete();
      prev = iv;
      // reference pt_k = ct_k ^ key ^ ct_(k-1)
      for (int k = 0; k < TESTS[t].blocks; k++) begin
        ct_blocks.push_back(random_block());
        plain = ct_blocks[k] ^ key ^ prev;
        expected_beats.push_back(beat_of(plain, 0));
        expected_beats.push_back(beat_of(plain, 1));
        prev = ct_blocks[k];
      end
      fork
        send_message(iv, TESTS[t].blocks);
        collect_plaintext(TESTS[t].stall, 2 * TESTS[t].blocks);
      join
      // no extra beat after the last expected one
      check_no_stray_beats(4);
      $display("test %0d: %0d blocks, stall %0b, new key %0b, %0d errors", t,
               TESTS[t].blocks, TESTS[t].stall, TESTS[t].new_key, errors - start_errors);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles()) @(posedge clk);
    $display("timeout: DUT stopped responding after %0d cycles", watchdog_cycles());
    $display("Something failed");
    $finish;
  end

endmodule

// File: verification/aes_core_model.sv
`timescale 1ns/1ps

module aes_decrypt_core import cbc_pkg::*; #(
  parameter int LANE = 0
) (
  input  logic     clk,
  input  logic     reset_n,
  core_bus_if.core bus
);

  // key expansion is slow
  // lanes finish in reverse order
  localparam int KE_LATENCY  = 8;
  localparam int DEC_LATENCY = 9 - 2 * LANE;

  logic [BLOCK_W-1:0] key;
  logic [BLOCK_W-1:0] block;
  logic [BLOCK_W-1:0] result;
  logic [BEAT_W-1:0]  rdata;
  logic [4:0]         count;
  logic               busy;
  logic               ready;

  always_ff @(posedge clk) begin
    if (bus.cs[LANE] && bus.we[LANE]) begin
      case (bus.address[LANE])
        ADDR_W'(KEY0):       key[BLOCK_W-1:BEAT_W]   <= bus.write_data[LANE];
        ADDR_W'(KEY0 + 1):   key[BEAT_W-1:0]         <= bus.write_data[LANE];
        ADDR_W'(BLOCK0):     block[BLOCK_W-1:BEAT_W] <= bus.write_data[LANE];
        ADDR_W'(BLOCK0 + 1): block[BEAT_W-1:0]       <= bus.write_data[LANE];
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      busy  <= 1'b0;
      ready <= 1'b0;
      count <= '0;
    end else begin
      if (busy) begin
        if (count == 0) begin
          busy   <= 1'b0;
          ready  <= 1'b1;
          // stand-in for the inverse cipher
          result <= block ^ key;
        end else begin
          count <= count - 1'b1;
        end
      end
      if (bus.cs[LANE] && bus.we[LANE] && bus.address[LANE] == ADDR_W'(CTRL)) begin
        if (bus.write_data[LANE][CTRL_INIT_BIT]) begin
          busy  <= 1'b1;
          ready <= 1'b0;
          count <= 5'(KE_LATENCY);
        end else if (bus.write_data[LANE][CTRL_NEXT_BIT]) begin
          busy  <= 1'b1;
          ready <= 1'b0;
          count <= 5'(DEC_LATENCY);
        end
      end
    end
  end

  // reads answer in the same cycle
  always_comb begin
    rdata = '0;
    if (bus.cs[LANE]) begin
      case (bus.address[LANE])
        ADDR_W'(STATUS):      rdata[STATUS_READY_BIT] = ready;
        ADDR_W'(RESULT0):     rdata = result[BLOCK_W-1:BEAT_W];
        ADDR_W'(RESULT0 + 1): rdata = result[BEAT_W-1:0];
        default: begin
        end
      endcase
    end
  end

  assign bus.read_data[LANE] = rdata;

endmodule

// File: verilog/aes_cbc_decrypt_top.sv
`timescale 1ns/1ps

module aes_cbc_decrypt_top import cbc_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [BEAT_W-1:0] key_tdata,
  input  logic              key_tvalid,
  output logic              key_tready,
  input  logic [BEAT_W-1:0] ct_tdata,
  input  logic              ct_tvalid,
  output logic              ct_tready,
  input  logic              ct_tlast,
  output logic [BEAT_W-1:0] pt_tdata,
  output logic              pt_tvalid,
  input  logic              pt_tready,
  output logic              pt_tlast
);

  logic [BLOCK_W-1:0] key_block;
  logic [BLOCK_W-1:0] ct_block;
  logic               key_done;
  logic               ct_done;
  logic               load_iv;
  logic               dispatch;
  logic               out_valid;
  logic               out_last;
  logic               out_ready;
  logic               read_word;
  logic [LANE_W-1:0]  lane;
  logic [BEAT_W-1:0]  result;
  logic [BEAT_W-1:0]  pt_beat;

  core_bus_if core_bus ();

  // --------------------------------------------------------------------------
  // input blocks
  // --------------------------------------------------------------------------
  block_assembler u_key_asm (
    .clk        (clk),
    .reset_n    (reset_n),
    .take       (key_tvalid && key_tready),
    .beat       (key_tdata),
    .block      (key_block),
    .block_done (key_done)
  );

  block_assembler u_ct_asm (
    .clk        (clk),
    .reset_n    (reset_n),
    .take       (ct_tvalid && ct_tready),
    .beat       (ct_tdata),
    .block      (ct_block),
    .block_done (ct_done)
  );

  cbc_controller u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .key_valid (key_tvalid),
    .key_ready (key_tready),
    .ct_valid  (ct_tvalid),
    .ct_ready  (ct_tready),
    .ct_last   (ct_tlast),
    .key_done  (key_done),
    .ct_done   (ct_done),
    .key_block (key_block),
    .ct_block  (ct_block),
    .bus       (core_bus.host),
    .load_iv   (load_iv),
    .dispatch  (dispatch),
    .out_valid (out_valid),
    .out_last  (out_last),
    .lane      (lane),
    .read_word (read_word),
    .out_ready (out_ready)
  );

  // --------------------------------------------------------------------------
  // lane cores and plaintext path
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    aes_decrypt_core #(.LANE(i)) u_core (
      .clk     (clk),
      .reset_n (reset_n),
      .bus     (core_bus.core)
    );
  end

  // result of the lane being drained
  assign result = core_bus.read_data[lane];

  iv_chain u_chain (
    .clk       (clk),
    .reset_n   (reset_n),
    .load_iv   (load_iv),
    .dispatch  (dispatch),
    .lane      (lane),
    .ct_block  (ct_block),
    .read_word (read_word),
    .result    (result),
    .pt_beat   (pt_beat)
  );

  axis_output_skid u_skid (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (out_valid),
    .in_last   (out_last),
    .in_data   (pt_beat),
    .in_ready  (out_ready),
    .pt_tdata  (pt_tdata),
    .pt_tvalid (pt_tvalid),
    .pt_tlast  (pt_tlast),
    .pt_tready (pt_tready)
  );

endmodule

// File: verilog/axis_output_skid.sv
`timescale 1ns/1ps

module axis_output_skid import cbc_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              in_valid,
  input  logic              in_last,
  input  logic [BEAT_W-1:0] in_data,
  output logic              in_ready,
  output logic [BEAT_W-1:0] pt_tdata,
  output logic              pt_tvalid,
  output logic              pt_tlast,
  input  logic              pt_tready
);

  logic [BEAT_W-1:0] temp_data;
  logic              temp_last;
  logic              temp_valid;
  logic              take;
  logic              out_free;

  assign in_ready = !temp_valid;
  assign take     = in_valid && in_ready;
  assign out_free = pt_tready || !pt_tvalid;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      pt_tvalid  <= 1'b0;
      temp_valid <= 1'b0;
    end else if (out_free) begin
      pt_tvalid  <= temp_valid || take;
      temp_valid <= 1'b0;
    end else if (take) begin
      temp_valid <= 1'b1;
    end
  end

  // spare slot refills the output slot first
  always_ff @(posedge clk) begin
    if (out_free && temp_valid) begin
      pt_tdata <= temp_data;
      pt_tlast <= temp_last;
    end else if (out_free && take) begin
      pt_tdata <= in_data;
      pt_tlast <= in_last;
    end
    if (!out_free && take) begin
      temp_data <= in_data;
      temp_last <= in_last;
    end
  end

  a_hold_stalled: assert property (
    @(posedge clk) disable iff (!reset_n)
    pt_tvalid && !pt_tready |=> pt_tvalid && $stable(pt_tdata) && $stable(pt_tlast)
  ) else $error("axis_output_skid: stalled beat changed");

endmodule

// File: verilog/iv_chain.sv
`timescale 1ns/1ps

module iv_chain import cbc_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               load_iv,
  input  logic               dispatch,
  input  logic [LANE_W-1:0]  lane,
  input  logic [BLOCK_W-1:0] ct_block,
  input  logic               read_word,
  input  logic [BEAT_W-1:0]  result,
  output logic [BEAT_W-1:0]  pt_beat
);

  logic [BLOCK_W-1:0] chain;
  logic [BLOCK_W-1:0] lane_iv [NUM_LANES];
  logic [BEAT_W-1:0]  iv_half;
  logic [BEAT_W-1:0]  plain;
  logic               iv_loaded;

  // ciphertext of each block chains into the next one
  always_ff @(posedge clk) begin
    if (load_iv || dispatch) chain <= ct_block;
    if (dispatch) lane_iv[lane] <= chain;
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      iv_loaded <= 1'b0;
    end else if (load_iv) begin
      iv_loaded <= 1'b1;
    end
  end

  assign iv_half = read_word ? lane_iv[lane][BEAT_W-1:0] : lane_iv[lane][BLOCK_W-1:BEAT_W];
  assign plain   = result ^ iv_half;

  // most significant byte leaves in the lowest tdata byte
  always_comb begin
    for (int j = 0; j < BEAT_W / 8; j++) begin
      pt_beat[8 * j +: 8] = plain[BEAT_W - 8 - 8 * j +: 8];
    end
  end

  // no block is dispatched before an IV has been loaded
  a_iv_before_dispatch: assert property (
    @(posedge clk) disable iff (!reset_n) dispatch |-> iv_loaded
  ) else $error("iv_chain: dispatch without a loaded IV");

endmodule

// File: verilog/cbc_controller.sv
`timescale 1ns/1ps

module cbc_controller import cbc_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               key_valid,
  output logic               key_ready,
  input  logic               ct_valid,
  output logic               ct_ready,
  input  logic               ct_last,
  input  logic               key_done,
  input  logic               ct_done,
  input  logic [BLOCK_W-1:0] key_block,
  input  logic [BLOCK_W-1:0] ct_block,
  core_bus_if.host           bus,
  output logic               load_iv,
  output logic               dispatch,
  output logic               out_valid,
  output logic               out_last,
  output logic [LANE_W-1:0]  lane,
  output logic               read_word,
  input  logic               out_ready
);

  ctrl_state_e state;

  logic              word;
  logic [LANE_W-1:0] load_mux;
  logic [LANE_W-1:0] out_mux;
  logic [LANE_W-1:0] last_lane;
  logic              last_seen;

  logic [NUM_LANES-1:0] sel;
  logic                 wr;
  logic [ADDR_W-1:0]    addr;
  logic [BEAT_W-1:0]    wdata;
  logic                 lane_ready;
  logic                 drained;

  // out_mux sits at lane 0 during key expansion
  assign lane_ready = bus.read_data[out_mux][STATUS_READY_BIT];
  assign drained    = out_mux == last_lane;

  assign dispatch  = state == START_DEC;
  assign out_valid = state == READ_OUTPUT;
  assign out_last  = out_valid && word && last_seen && drained;
  assign lane      = out_valid ? out_mux : load_mux;
  assign read_word = word;

  // --------------------------------------------------------------------------
  // register bus
  // --------------------------------------------------------------------------
  always_comb begin
    sel   = '0;
    wr    = 1'b0;
    addr  = STATUS;
    wdata = '0;
    case (state)
      LOAD_KEY: begin
        sel   = '1;
        wr    = 1'b1;
        addr  = KEY0 + ADDR_W'(word);
        wdata = word ? key_block[BEAT_W-1:0] : key_block[BLOCK_W-1:BEAT_W];
      end
      START_KE: begin
        sel                  = '1;
        wr                   = 1'b1;
        addr                 = CTRL;
        wdata[CTRL_INIT_BIT] = 1'b1;
      end
      LOAD_CT: begin
        sel[load_mux] = 1'b1;
        wr            = 1'b1;
        addr          = BLOCK0 + ADDR_W'(word);
        wdata         = word ? ct_block[BEAT_W-1:0] : ct_block[BLOCK_W-1:BEAT_W];
      end
      START_DEC: begin
        sel[load_mux]        = 1'b1;
        wr                   = 1'b1;
        addr                 = CTRL;
        wdata[CTRL_NEXT_BIT] = 1'b1;
      end
      WAIT_KE, WAIT_DEC: begin
        sel[out_mux] = 1'b1;
      end
      READ_OUTPUT: begin
        sel[out_mux] = 1'b1;
        addr         = RESULT0 + ADDR_W'(word);
      end
      default: begin
      end
    endcase
  end

  assign bus.cs = sel;
  assign bus.we = sel & {NUM_LANES{wr}};

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_bus
    assign bus.address[i]    = addr;
    assign bus.write_data[i] = wdata;
  end

  // --------------------------------------------------------------------------
  // sequencing
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= IDLE;
      key_ready <= 1'b0;
      ct_ready  <= 1'b0;
      load_iv   <= 1'b0;
      word      <= 1'b0;
      load_mux  <= '0;
      out_mux   <= '0;
      last_lane <= '0;
      last_seen <= 1'b0;
    end else begin
      // readies rise only after valid is seen
      key_ready <= (state == IDLE && key_valid) || (state == READ_KEY && !key_done);
      ct_ready  <= (state == READ_IV && (ct_valid || ct_ready)) ||
                   (state == READ_CT && !ct_done && (ct_valid || ct_ready));
      // IV block is complete the cycle after its second beat
      load_iv   <= state == READ_IV && ct_done;
      case (state)
        IDLE: begin
          if (key_valid) state <= READ_KEY;
        end
        READ_KEY: begin
          if (key_done) state <= LOAD_KEY;
        end
        LOAD_KEY: begin
          word <= !word;
          if (word) state <= START_KE;
        end
        START_KE: begin
          state <= WAIT_KE;
        end
        WAIT_KE: begin
          if (lane_ready) state <= READ_IV;
        end
        READ_IV: begin
          if (ct_done) state <= READ_CT;
        end
        READ_CT: begin
          if (ct_done) begin
            last_seen <= ct_last;
            state     <= LOAD_CT;
          end
        end
        LOAD_CT: begin
          word <= !word;
          if (word) state <= START_DEC;
        end
        START_DEC: begin
          load_mux <= load_mux + 1'b1;
          if (last_seen || load_mux == LANE_W'(NUM_LANES - 1)) begin
            last_lane <= load_mux;
            state     <= WAIT_DEC;
          end else begin
            state <= READ_CT;
          end
        end
        WAIT_DEC: begin
          if (lane_ready) state <= READ_OUTPUT;
        end
        READ_OUTPUT: begin
          // stall here while the skid buffer is full
          if (out_ready) begin
            word <= !word;
            if (word) begin
              out_mux <= out_mux + 1'b1;
              if (drained && last_seen) begin
                load_mux  <= '0;
                out_mux   <= '0;
                last_seen <= 1'b0;
                state     <= READ_IV;
              end else if (drained) begin
                state <= READ_CT;
              end else begin
                state <= WAIT_DEC;
              end
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // only the key broadcast may select several lanes
  a_one_lane: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(state inside {LOAD_KEY, START_KE}) |-> $onehot0(bus.cs)
  ) else $error("cbc_controller: more than one lane selected");

endmodule

// File: verilog/block_assembler.sv
`timescale 1ns/1ps

module block_assembler import cbc_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               take,
  input  logic [BEAT_W-1:0]  beat,
  output logic [BLOCK_W-1:0] block,
  output logic               block_done
);

  logic [$clog2(BEATS_PER_BLOCK)-1:0] word;

  assign block_done = take && (int'(word) == BEATS_PER_BLOCK - 1);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      word <= '0;
    end else if (take) begin
      word <= block_done ? '0 : word + 1'b1;
    end
  end

  // lowest tdata byte is the most significant block byte of this word
  always_ff @(posedge clk) begin
    if (take) begin
      for (int j = 0; j < BEAT_W / 8; j++) begin
        block[BLOCK_W - 1 - 8 * ((BEAT_W / 8) * int'(word) + j) -: 8] <= beat[8 * j +: 8];
      end
    end
  end

  // stream handshake must stay quiet while the controller is held in reset
  a_no_take_in_reset: assert property (
    @(posedge clk) !reset_n |-> !take
  ) else $error("block_assembler: beat taken during reset");

endmodule

// File: verilog/core_bus_if.sv
`timescale 1ns/1ps

interface core_bus_if import cbc_pkg::*; ();

  // one register bus per lane core
  logic [NUM_LANES-1:0] cs;
  logic [NUM_LANES-1:0] we;
  logic [ADDR_W-1:0]    address    [NUM_LANES];
  logic [BEAT_W-1:0]    write_data [NUM_LANES];
  logic [BEAT_W-1:0]    read_data  [NUM_LANES];

  modport host (
    output cs, we, address, write_data,
    input  read_data
  );

  modport core (
    input  cs, we, address, write_data,
    output read_data
  );

endinterface

// File: verilog/cbc_pkg.sv
package cbc_pkg;

  // stream and block widths
  localparam int BEAT_W          = 64;
  localparam int BLOCK_W         = 128;
  localparam int BEATS_PER_BLOCK = 2;

  // lane cores
  localparam int NUM_LANES = 4;
  localparam int LANE_W    = 2;
  localparam int ADDR_W    = 8;

  // core register map
  // word offset is added to KEY0, BLOCK0 and RESULT0
  typedef enum logic [7:0] {
    CTRL    = 8'h08,
    STATUS  = 8'h09,
    KEY0    = 8'h10,
    BLOCK0  = 8'h20,
    RESULT0 = 8'h30
  } core_reg_e;

  localparam int CTRL_INIT_BIT    = 0;
  localparam int CTRL_NEXT_BIT    = 1;
  localparam int STATUS_READY_BIT = 0;

  typedef enum logic [3:0] {
    IDLE,
    READ_KEY,
    LOAD_KEY,
    START_KE,
    WAIT_KE,
    READ_IV,
    READ_CT,
    LOAD_CT,
    START_DEC,
    WAIT_DEC,
    READ_OUTPUT
  } ctrl_state_e;

endpackage
